/* src/bubblePkg.sv */
package bubblePkg;

    // ========================================================================
    // page bit addressing
    // ========================================================================

    // split view of a page bit index
    typedef struct packed {
        logic [9:0] byteAddr;
        logic [2:0] bitSel;
    } bitSplitT;

    // counted as flat, decoded as split
    typedef union packed {
        logic [12:0] flat;
        bitSplitT    split;
    } bitAddrT;

    // ========================================================================
    // stream and host side
    // ========================================================================

    // one bubble bit, start marks bit 0 of a page
    typedef struct packed {
        logic valid;
        logic start;
        logic data;
    } serialBitT;

    typedef struct packed {
        logic done;
        logic crcOk;
    } pageStatusT;

    typedef struct packed {
        logic [7:0] data;
        pageStatusT status;
    } readReplyT;

    // CRC-16 CCITT, non-reflected, no final xor
    localparam logic [15:0] crcPoly = 16'h1021;
    localparam logic [15:0] crcInit = 16'hFFFF;

endpackage

/* src/ram1k1.sv */
module ram1k1
(
    input  logic       MCLK,

    input  logic [9:0] rdAddr,
    input  logic [9:0] wrAddr,
    input  logic       din,
    output logic       dout,

    input  logic       nWe,
    input  logic       nRdClkEn,
    input  logic       nWrClkEn
);

    logic mem [0:1023];

    // write needs both the column select and the strobe
    always_ff @(posedge MCLK)
    begin
        if (!nWe && !nWrClkEn)
            mem[wrAddr] <= din;
    end

    // registered read port
    always_ff @(posedge MCLK)
    begin
        if (!nRdClkEn)
            dout <= mem[rdAddr];
    end

endmodule

/* src/sipoBuffer.sv */
module sipoBuffer
    import bubblePkg::*;
(
    input  logic       MCLK,

    // bit-addressed write side
    input  bitAddrT    wrAddr,
    input  logic       wrData,
    input  logic       nWrClkEn,

    // byte-wide read side
    input  logic [9:0] rdAddr,
    output logic [7:0] rdData,
    input  logic       nRdClkEn
);

    logic [7:0] nColWe;

    // bitSel 0 is the first bit of a byte and goes to column 7
    always_comb
    begin
        nColWe = ~(8'h80 >> wrAddr.split.bitSel) | {8{nWrClkEn}};
    end

    // ========================================================================
    // eight 1k x 1 columns, one per data bit
    // ========================================================================

    for (genvar col = 0; col < 8; col++)
    begin : gCol
        ram1k1 uCol
        (
            .MCLK       (MCLK                   ),
            .rdAddr     (rdAddr                 ),
            .wrAddr     (wrAddr.split.byteAddr  ),
            .din        (wrData                 ),
            .dout       (rdData[col]            ),
            .nWe        (nColWe[col]            ),
            .nRdClkEn   (nRdClkEn               ),
            .nWrClkEn   (nWrClkEn               )
        );
    end

endmodule

/* src/bitCollector.sv */
module bitCollector
    import bubblePkg::*;
#(
    parameter int PageBytes = 64
)
(
    input  logic      MCLK,
    input  logic      rstN,

    input  serialBitT streamIn,

    output bitAddrT   wrAddr,
    output logic      wrData,
    output logic      nWrClkEn,
    output logic      pageDone
);

    localparam logic [12:0] DataBits = 13'(PageBytes * 8);
    localparam logic [12:0] LastBit  = 13'(PageBytes * 8 + 15);

    bitAddrT bitCnt;
    bitAddrT bitIdx;
    logic    inPage;
    logic    take;

    // index of the bit being sampled now
    always_comb
    begin
        bitIdx.flat = streamIn.start ? 13'd0 : bitCnt.flat;
        take        = streamIn.valid && (streamIn.start || inPage);
    end

    always_ff @(posedge MCLK or negedge rstN)
    begin
        if (!rstN)
        begin
            bitCnt.flat <= '0;
            inPage      <= 1'b0;
            pageDone    <= 1'b0;
            nWrClkEn    <= 1'b1;
        end
        else
        begin
            nWrClkEn <= 1'b1;
            if (take)
            begin
                bitCnt.flat <= bitIdx.flat + 13'd1;
                inPage      <= (bitIdx.flat != LastBit);
                // holds once set, until the next start
                pageDone    <= (bitIdx.flat == LastBit);
                // crc bits are counted but not stored
                if (bitIdx.flat < DataBits)
                    nWrClkEn <= 1'b0;
            end
        end
    end

    // write address and data go out with the strobe
    always_ff @(posedge MCLK)
    begin
        if (take)
        begin
            wrAddr <= bitIdx;
            wrData <= streamIn.data;
        end
    end

endmodule

/* src/pageCrc.sv */
module pageCrc
    import bubblePkg::*;
(
    input  logic      MCLK,
    input  logic      rstN,

    input  serialBitT streamIn,

    output logic      crcOk
);

    logic [15:0] crcReg;
    logic [15:0] seed;
    logic [15:0] nextCrc;
    logic        feedback;

    // start presets the register before its own bit is shifted in
    always_comb
    begin
        seed     = streamIn.start ? crcInit : crcReg;
        feedback = seed[15] ^ streamIn.data;
        nextCrc  = {seed[14:0], 1'b0} ^ (feedback ? crcPoly : 16'h0000);
    end

    // stream idles between pages, so every valid bit belongs to one
    always_ff @(posedge MCLK or negedge rstN)
    begin
        if (!rstN)
            crcReg <= crcInit;
        else if (streamIn.valid)
            crcReg <= nextCrc;
    end

    // zero residue once the trailing crc is in
    assign crcOk = (crcReg == 16'h0000);

endmodule

/* src/pageReader.sv */
module pageReader
    import bubblePkg::*;
#(
    parameter int PageBytes = 64
)
(
    input  logic       MCLK,
    input  logic       rstN,

    // host side, four-phase
    input  logic       readReq,
    input  logic [9:0] readAddr,
    output logic       readAck,
    output readReplyT  reply,

    // buffer read port
    output logic [9:0] rdAddr,
    output logic       nRdClkEn,
    input  logic [7:0] rdData,

    input  logic       pageDone,
    input  logic       crcOk
);

    typedef enum logic [1:0] {
        sIdle,
        sRead,
        sAck
    } stateT;

    stateT state;

    // ========================================================================
    // handshake FSM
    // ========================================================================

    // sRead lasts two cycles, the first with the RAM clock enable low
    always_ff @(posedge MCLK or negedge rstN)
    begin
        if (!rstN)
        begin
            state    <= sIdle;
            nRdClkEn <= 1'b1;
            reply    <= '0;
        end
        else
        begin
            case (state)
                sIdle:
                begin
                    if (readReq)
                    begin
                        state    <= sRead;
                        nRdClkEn <= 1'b0;
                    end
                end
                sRead:
                begin
                    if (!nRdClkEn)
                        nRdClkEn <= 1'b1;
                    else
                    begin
                        state              <= sAck;
                        reply.data         <= (rdAddr < 10'(PageBytes)) ? rdData : 8'h00;
                        reply.status.done  <= pageDone;
                        reply.status.crcOk <= pageDone & crcOk;
                    end
                end
                sAck:
                begin
                    if (!readReq)
                        state <= sIdle;
                end
                default:
                    state <= sIdle;
            endcase
        end
    end

    // address is held by the host, capture once
    always_ff @(posedge MCLK)
    begin
        if (state == sIdle && readReq)
            rdAddr <= readAddr;
    end

    assign readAck = (state == sAck);

endmodule

/* src/bubblePageBuffer.sv */
module bubblePageBuffer
    import bubblePkg::*;
#(
    parameter int PageBytes = 64
)
(
    input  logic       MCLK,
    input  logic       rstN,

    // bubble stream
    input  serialBitT  streamIn,

    // host read port
    input  logic       readReq,
    input  logic [9:0] readAddr,
    output logic       readAck,
    output readReplyT  reply
);

    bitAddrT    wrAddr;
    logic       wrData;
    logic       nWrClkEn;
    logic       pageDone;
    logic       crcOk;
    logic [9:0] rdAddr;
    logic [7:0] rdData;
    logic       nRdClkEn;

    // ========================================================================
    // write side, collector and crc watch the same stream
    // ========================================================================

    bitCollector #(
        .PageBytes  (PageBytes  )
    ) uCollector
    (
        .MCLK       (MCLK       ),
        .rstN       (rstN       ),
        .streamIn   (streamIn   ),
        .wrAddr     (wrAddr     ),
        .wrData     (wrData     ),
        .nWrClkEn   (nWrClkEn   ),
        .pageDone   (pageDone   )
    );

    pageCrc uCrc
    (
        .MCLK       (MCLK       ),
        .rstN       (rstN       ),
        .streamIn   (streamIn   ),
        .crcOk      (crcOk      )
    );

    sipoBuffer uBuffer
    (
        .MCLK       (MCLK       ),
        .wrAddr     (wrAddr     ),
        .wrData     (wrData     ),
        .nWrClkEn   (nWrClkEn   ),
        .rdAddr     (rdAddr     ),
        .rdData     (rdData     ),
        .nRdClkEn   (nRdClkEn   )
    );

    // host side
    pageReader #(
        .PageBytes  (PageBytes  )
    ) uReader
    (
        .MCLK       (MCLK       ),
        .rstN       (rstN       ),
        .readReq    (readReq    ),
        .readAddr   (readAddr   ),
        .readAck    (readAck    ),
        .reply      (reply      ),
        .rdAddr     (rdAddr     ),
        .nRdClkEn   (nRdClkEn   ),
        .rdData     (rdData     ),
        .pageDone   (pageDone   ),
        .crcOk      (crcOk      )
    );

endmodule

/* sim/bubblePageBuffer_properties.sv */
module bubblePageBufferProperties
(
    input  logic MCLK,
    input  logic rstN,
    input  logic readReq,
    input  logic readAck,
    input  logic nWrClkEn,
    input  logic pageDone
);

    timeunit 1ns;
    timeprecision 100ps;

    // watched by the testbench
    int unsigned failCount = 0;

    // ack only answers a pending request
    ackNeedsReq: assert property (@(posedge MCLK) disable iff (!rstN)
        $rose(readAck) |-> readReq)
    else
    begin
        failCount++;
        $error("readAck rose while readReq was low");
    end

    // four-phase, ack held until the host lets go
    ackHeld: assert property (@(posedge MCLK) disable iff (!rstN)
        (readAck && readReq) |=> readAck)
    else
    begin
        failCount++;
        $error("readAck dropped while readReq was still high");
    end

    // crc bits and idle time never write the RAM
    noWriteAfterDone: assert property (@(posedge MCLK) disable iff (!rstN)
        pageDone |-> nWrClkEn)
    else
    begin
        failCount++;
        $error("write strobe active after page completion");
    end

endmodule

bind bubblePageBuffer bubblePageBufferProperties props0
(
    .MCLK       (MCLK       ),
    .rstN       (rstN       ),
    .readReq    (readReq    ),
    .readAck    (readAck    ),
    .nWrClkEn   (nWrClkEn   ),
    .pageDone   (pageDone   )
);

/* sim/tbBubblePageBuffer.sv */
module tbBubblePageBuffer
    import bubblePkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int PageBytes   = 16;
    localparam int DataBits    = PageBytes * 8;
    localparam int TotalBits   = DataBits + 16;
    localparam int ResetCycles = 16;
    localparam int NumPages    = 6;
    localparam int CycleLimit  = NumPages * (PageBytes * 8 + 16 + PageBytes * 6 + 50)
                                 + ResetCycles;

    typedef enum logic [1:0] {
        patRandom,
        patRamp,
        patOnes
    } patternT;

    typedef struct packed {
        patternT kind;
        logic    doFlip;
        int      flipBit;
        logic    expCrcOk;
        logic    midRead;
    } pageCaseT;

    // kind, flip, flipped stream bit, crcOk, read before crc
    localparam pageCaseT PageTable [NumPages] = '{
        '{patRamp,   1'b0, 0,   1'b1, 1'b1},
        '{patRandom, 1'b0, 0,   1'b1, 1'b0},
        '{patRandom, 1'b1, 37,  1'b0, 1'b0},
        '{patOnes,   1'b0, 0,   1'b1, 1'b1},
        '{patRandom, 1'b1, 140, 1'b0, 1'b0},
        '{patRamp,   1'b0, 0,   1'b1, 1'b0}
    };

    logic       MCLK;
    logic       rstN;
    serialBitT  streamIn;
    logic       readReq;
    logic [9:0] readAddr;
    logic       readAck;
    readReplyT  reply;

    logic [7:0] pageBytes [PageBytes + 2];
    int         bitsSent;
    int         cycleCount;

    bubblePageBuffer #(
        .PageBytes  (PageBytes  )
    ) dut0
    (
        .MCLK       (MCLK       ),
        .rstN       (rstN       ),
        .streamIn   (streamIn   ),
        .readReq    (readReq    ),
        .readAddr   (readAddr   ),
        .readAck    (readAck    ),
        .reply      (reply      )
    );

    initial
    begin
        MCLK = 1'b0;
        forever #2 MCLK = ~MCLK;
    end

    // ========================================================================
    // reporting and compares
    // ========================================================================

    task automatic stopOnError(string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic checkByte(string name, logic [7:0] got, logic [7:0] exp);
        if (got !== exp)
            stopOnError($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic checkStatus(string name, pageStatusT got, pageStatusT exp);
        if (got !== exp)
            stopOnError($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic checkBit(string name, logic got, logic exp);
        if (got !== exp)
            stopOnError($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    // byte-wise CRC-16 over the first count model bytes taken msb first
    function automatic logic [15:0] crcOfBytes(int count);
        logic [15:0] crc;
        crc = crcInit;
        for (int n = 0; n < count; n++)
        begin
            crc ^= {pageBytes[n], 8'h00};
            for (int b = 0; b < 8; b++)
                crc = crc[15] ? ((crc << 1) ^ crcPoly) : (crc << 1);
        end
        return crc;
    endfunction

    task automatic buildPage(pageCaseT pc);
        logic [15:0] crc;
        for (int n = 0; n < PageBytes; n++)
        begin
            case (pc.kind)
                patRandom: pageBytes[n] = 8'($urandom);
                patRamp:   pageBytes[n] = 8'(n);
                default:   pageBytes[n] = 8'hFF;
            endcase
        end
        // sealed data leaves a zero residue before the crc bits arrive
        if (pc.midRead)
        begin
            crc = crcOfBytes(PageBytes - 2);
            pageBytes[PageBytes - 2] = crc[15:8];
            pageBytes[PageBytes - 1] = crc[7:0];
        end
        crc = crcOfBytes(PageBytes);
        pageBytes[PageBytes]     = crc[15:8];
        pageBytes[PageBytes + 1] = crc[7:0];
        if (pc.doFlip)
            pageBytes[pc.flipBit / 8][7 - (pc.flipBit % 8)] ^= 1'b1;
    endtask

    task automatic streamPage();
        for (int i = 0; i < TotalBits; i++)
        begin
            @(posedge MCLK);
            streamIn <= '{1'b1, (i == 0), pageBytes[i / 8][7 - (i % 8)]};
            bitsSent = i + 1;
        end
        @(posedge MCLK);
        streamIn <= '0;
    endtask

    task automatic readByte(int addr, logic [7:0] expData, pageStatusT expStatus);
        @(posedge MCLK);
        readReq  <= 1'b1;
        readAddr <= 10'(addr);
        do
            @(posedge MCLK);
        while (readAck !== 1'b1);
        checkByte($sformatf("reply.data[%0d]", addr), reply.data, expData);
        checkStatus($sformatf("reply.status[%0d]", addr), reply.status, expStatus);
        readReq <= 1'b0;
        do
            @(posedge MCLK);
        while (readAck !== 1'b0);
    endtask

    task automatic runPage(pageCaseT pc);
        buildPage(pc);
        bitsSent = 0;
        fork
            streamPage();
            begin
                // host read while the crc is still arriving
                if (pc.midRead)
                begin
                    wait (bitsSent >= DataBits);
                    readByte(0, pageBytes[0], '0);
                end
            end
        join
        for (int a = 0; a <= PageBytes; a++)
            readByte(a, (a < PageBytes) ? pageBytes[a] : 8'h00, '{1'b1, pc.expCrcOk});
    endtask

    // ========================================================================
    // watchdog
    // ========================================================================

    initial
    begin
        cycleCount = 0;
        forever
        begin
            @(posedge MCLK);
            cycleCount++;
            if (cycleCount > CycleLimit)
                stopOnError($sformatf("timeout: run still busy after %0d cycles", CycleLimit));
            else if (dut0.props0.failCount != 0)
                stopOnError("a bound assertion on the DUT failed");
        end
    end

    initial
    begin
        void'($urandom(32'h8a88));
        rstN     = 1'b0;
        streamIn = '0;
        readReq  = 1'b0;
        readAddr = '0;
        bitsSent = 0;
        repeat (ResetCycles) @(posedge MCLK);
        rstN <= 1'b1;
        @(posedge MCLK);
        checkBit("readAck", readAck, 1'b0);
        checkBit("nWrClkEn", dut0.nWrClkEn, 1'b1);
        checkStatus("reply.status", reply.status, '0);

        for (int p = 0; p < NumPages; p++)
            runPage(PageTable[p]);

        repeat (2) @(posedge MCLK);
        if (dut0.props0.failCount != 0)
            stopOnError("a bound assertion on the DUT failed");
        else
        begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

/* bubblePageBuffer.f */
src/bubblePkg.sv
src/ram1k1.sv
src/sipoBuffer.sv
src/bitCollector.sv
src/pageCrc.sv
src/pageReader.sv
src/bubblePageBuffer.sv
sim/bubblePageBuffer_properties.sv
sim/tbBubblePageBuffer.sv

/* Bender.yml */
package:
  name: bubblePageBuffer

sources:
  - files:
      - src/bubblePkg.sv
      - src/ram1k1.sv
      - src/sipoBuffer.sv
      - src/bitCollector.sv
      - src/pageCrc.sv
      - src/pageReader.sv
      - src/bubblePageBuffer.sv
  - target: simulation
    files:
      - sim/bubblePageBuffer_properties.sv
      - sim/tbBubblePageBuffer.sv
